//--- mpad_defines.svh
// Widths and tile constants for the matrix padding DMA engine
// Included by the package and by every RTL file that needs a width

`ifndef MPAD_DEFINES_SVH
`define MPAD_DEFINES_SVH

// Byte address width on both AXI channels
`define MPAD_ADDR_W 32

// One matrix element
`define MPAD_DATA_W 32

// Matrix width and tile coordinates
`define MPAD_DIM_W 6

// Tile edge in words, also the read burst length
`define MPAD_TILE 4

`define MPAD_WORD_BYTES 4 // Byte stride per word
`define MPAD_LEN_W 4      // AXI arlen/awlen field

`endif

//--- mpad_pkg.sv
// Shared types of the matrix padding DMA engine
// Stage modules refer to these by scoped names

`include "mpad_defines.svh"

package mpad_pkg;

    typedef logic [`MPAD_ADDR_W-1:0] addr_t; // Byte address
    typedef logic [`MPAD_DATA_W-1:0] word_t; // One matrix element
    typedef logic [`MPAD_DIM_W-1:0]  dim_t;  // Width or tile coordinate

    // Row-major, word 0 is row 0 column 0
    typedef logic [`MPAD_TILE*`MPAD_TILE*`MPAD_DATA_W-1:0] tile_t;

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_ISSUE, SEQ_DRAIN} seq_state_e;

    // Reader walks four AR/R bursts then hands the tile on
    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA, RD_HAND} rd_state_e;

    typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_e;

endpackage

//--- mpad_tile_seq.sv
// Tile sequencer: takes the start command and walks tiles in row-major order
// Emits one descriptor with edge flags per tile, then waits for the job end

`include "mpad_defines.svh"

module mpad_tile_seq (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start_i,
    input  mpad_pkg::dim_t  width_i,
    input  mpad_pkg::addr_t src_addr_i,
    input  mpad_pkg::addr_t dst_addr_i,
    output logic            done_o,
    output logic            desc_valid_o,
    input  logic            desc_ready_i,
    output mpad_pkg::dim_t  tile_x_o,
    output mpad_pkg::dim_t  tile_y_o,
    output logic            edge_top_o,
    output logic            edge_bottom_o,
    output logic            edge_left_o,
    output logic            edge_right_o,
    output logic            tile_last_o,
    output mpad_pkg::dim_t  mat_width_o,
    output mpad_pkg::addr_t src_base_o,
    output mpad_pkg::addr_t dst_base_o,
    input  logic            job_end_i
);
    mpad_pkg::seq_state_e state_q;
    mpad_pkg::dim_t       tile_x_q;
    mpad_pkg::dim_t       tile_y_q;
    mpad_pkg::dim_t       tiles_m1; // Last tile coordinate, W/4-1

    assign tiles_m1 = mpad_pkg::dim_t'(mat_width_o / `MPAD_TILE) - mpad_pkg::dim_t'(1);

    assign done_o        = (state_q == mpad_pkg::SEQ_IDLE);
    assign desc_valid_o  = (state_q == mpad_pkg::SEQ_ISSUE);
    assign tile_x_o      = tile_x_q;
    assign tile_y_o      = tile_y_q;
    assign edge_top_o    = (tile_y_q == '0);
    assign edge_bottom_o = (tile_y_q == tiles_m1);
    assign edge_left_o   = (tile_x_q == '0);
    assign edge_right_o  = (tile_x_q == tiles_m1);
    assign tile_last_o   = edge_bottom_o && edge_right_o;

    // Command copies, held for the whole job
    always_ff @(posedge clk) begin
        if (state_q == mpad_pkg::SEQ_IDLE && start_i) begin
            mat_width_o <= width_i;
            src_base_o  <= src_addr_i;
            dst_base_o  <= dst_addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= mpad_pkg::SEQ_IDLE;
            tile_x_q <= '0;
            tile_y_q <= '0;
        end else begin
            case (state_q)
                mpad_pkg::SEQ_IDLE: begin
                    if (start_i && width_i != '0) begin // Zero width is ignored
                        tile_x_q <= '0;
                        tile_y_q <= '0;
                        state_q  <= mpad_pkg::SEQ_ISSUE;
                    end
                end
                mpad_pkg::SEQ_ISSUE: begin
                    if (desc_ready_i) begin
                        if (tile_last_o) begin
                            state_q <= mpad_pkg::SEQ_DRAIN;
                        end else if (edge_right_o) begin // Wrap to next tile row
                            tile_x_q <= '0;
                            tile_y_q <= tile_y_q + mpad_pkg::dim_t'(1);
                        end else begin
                            tile_x_q <= tile_x_q + mpad_pkg::dim_t'(1);
                        end
                    end
                end
                default: begin
                    // Last tile still in the reader or writer
                    if (job_end_i) begin
                        state_q <= mpad_pkg::SEQ_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- mpad_tile_reader.sv
// Tile reader: fetches one 4x4 tile per descriptor as four AXI read bursts
// The gathered tile and its descriptor are offered to the writer

`include "mpad_defines.svh"

module mpad_tile_reader (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            desc_valid_i,
    output logic            desc_ready_o,
    input  mpad_pkg::dim_t  tile_x_i,
    input  mpad_pkg::dim_t  tile_y_i,
    input  logic            edge_top_i,
    input  logic            edge_bottom_i,
    input  logic            edge_left_i,
    input  logic            edge_right_i,
    input  logic            tile_last_i,
    input  mpad_pkg::dim_t  mat_width_i,
    input  mpad_pkg::addr_t src_base_i,
    output mpad_pkg::addr_t araddr_o,
    output logic [`MPAD_LEN_W-1:0] arlen_o,
    output logic            arvalid_o,
    input  logic            arready_i,
    input  mpad_pkg::word_t rdata_i,
    input  logic            rlast_i,
    input  logic            rvalid_i,
    output logic            rready_o,
    output logic            tile_valid_o,
    input  logic            tile_ready_i,
    output mpad_pkg::tile_t tile_o,
    output mpad_pkg::dim_t  tile_x_o,
    output mpad_pkg::dim_t  tile_y_o,
    output logic            edge_top_o,
    output logic            edge_bottom_o,
    output logic            edge_left_o,
    output logic            edge_right_o,
    output logic            tile_last_o
);
    mpad_pkg::rd_state_e state_q;
    logic [1:0]          row_q;  // Tile row being fetched
    logic [1:0]          beat_q; // Word within the burst
    mpad_pkg::addr_t     src_row;
    mpad_pkg::addr_t     src_col;

    assign desc_ready_o = (state_q == mpad_pkg::RD_IDLE);
    assign arvalid_o    = (state_q == mpad_pkg::RD_ADDR);
    assign rready_o     = (state_q == mpad_pkg::RD_DATA);
    assign tile_valid_o = (state_q == mpad_pkg::RD_HAND);
    assign arlen_o      = `MPAD_LEN_W'(`MPAD_TILE - 1); // Always four beats

    // Row start in the source matrix
    assign src_row  = mpad_pkg::addr_t'(tile_y_o) * `MPAD_TILE + mpad_pkg::addr_t'(row_q);
    assign src_col  = mpad_pkg::addr_t'(tile_x_o) * `MPAD_TILE;
    assign araddr_o = src_base_i
                    + (src_row * mpad_pkg::addr_t'(mat_width_i) + src_col) * `MPAD_WORD_BYTES;

    // Descriptor copy and tile gather
    always_ff @(posedge clk) begin
        if (desc_valid_i && desc_ready_o) begin
            tile_x_o      <= tile_x_i;
            tile_y_o      <= tile_y_i;
            edge_top_o    <= edge_top_i;
            edge_bottom_o <= edge_bottom_i;
            edge_left_o   <= edge_left_i;
            edge_right_o  <= edge_right_i;
            tile_last_o   <= tile_last_i;
        end
        if (rvalid_i && rready_o) begin
            tile_o[{row_q, beat_q} * `MPAD_DATA_W +: `MPAD_DATA_W] <= rdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= mpad_pkg::RD_IDLE;
            row_q   <= '0;
            beat_q  <= '0;
        end else begin
            case (state_q)
                mpad_pkg::RD_IDLE: begin
                    if (desc_valid_i) begin
                        row_q   <= '0;
                        state_q <= mpad_pkg::RD_ADDR;
                    end
                end
                mpad_pkg::RD_ADDR: begin
                    if (arready_i) begin
                        beat_q  <= '0;
                        state_q <= mpad_pkg::RD_DATA;
                    end
                end
                mpad_pkg::RD_DATA: begin
                    if (rvalid_i) begin
                        beat_q <= beat_q + 2'd1;
                        if (rlast_i) begin
                            row_q   <= row_q + 2'd1;
                            state_q <= (row_q == 2'd3) ? mpad_pkg::RD_HAND
                                                       : mpad_pkg::RD_ADDR;
                        end
                    end
                end
                default: begin
                    if (tile_ready_i) begin // Writer took its copy
                        state_q <= mpad_pkg::RD_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- mpad_tile_writer.sv
// Tile writer: holds one tile and writes its padded rows as AXI write bursts
// Edge tiles add a reflected pad row or column, one burst per output row

`include "mpad_defines.svh"

module mpad_tile_writer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            tile_valid_i,
    output logic            tile_ready_o,
    input  mpad_pkg::tile_t tile_i,
    input  mpad_pkg::dim_t  tile_x_i,
    input  mpad_pkg::dim_t  tile_y_i,
    input  logic            edge_top_i,
    input  logic            edge_bottom_i,
    input  logic            edge_left_i,
    input  logic            edge_right_i,
    input  logic            tile_last_i,
    input  mpad_pkg::dim_t  mat_width_i,
    input  mpad_pkg::addr_t dst_base_i,
    output mpad_pkg::addr_t awaddr_o,
    output logic [`MPAD_LEN_W-1:0] awlen_o,
    output logic            awvalid_o,
    input  logic            awready_i,
    output mpad_pkg::word_t wdata_o,
    output logic            wlast_o,
    output logic            wvalid_o,
    input  logic            wready_i,
    input  logic            bvalid_i,
    output logic            bready_o,
    output logic            job_end_o
);
    mpad_pkg::wr_state_e state_q;
    mpad_pkg::tile_t     tile_q;
    mpad_pkg::dim_t      tile_x_q;
    mpad_pkg::dim_t      tile_y_q;
    logic                top_q;
    logic                bottom_q;
    logic                left_q;
    logic                right_q;
    logic                last_q;
    logic [2:0]          row_q;    // Output row within the tile
    logic [2:0]          col_q;    // Beat within the row burst
    logic [2:0]          n_rows;
    logic [2:0]          n_cols;
    logic [1:0]          src_r;
    logic [1:0]          src_c;
    mpad_pkg::addr_t     pad_row;
    mpad_pkg::addr_t     pad_col;
    logic                last_row;

    // Output position to tile row or column, reflecting at the matrix edge
    function automatic logic [1:0] reflect(input logic [2:0] pos, input logic pad_lo);
        logic [2:0] rel;
        rel = pos - {2'b00, pad_lo};
        if (pad_lo && pos == 3'd0) begin
            return 2'd1; // Low pad mirrors row/col 1
        end
        if (rel == 3'd4) begin
            return 2'd2; // High pad mirrors row/col 2
        end
        return rel[1:0];
    endfunction

    assign n_rows   = 3'd4 + {2'b00, top_q} + {2'b00, bottom_q};
    assign n_cols   = 3'd4 + {2'b00, left_q} + {2'b00, right_q};
    assign last_row = (row_q == n_rows - 3'd1);

    assign src_r   = reflect(row_q, top_q);
    assign src_c   = reflect(col_q, left_q);
    assign wdata_o = tile_q[{src_r, src_c} * `MPAD_DATA_W +: `MPAD_DATA_W];

    // Segment start in the padded (W+2) square
    assign pad_row  = mpad_pkg::addr_t'(tile_y_q) * `MPAD_TILE + mpad_pkg::addr_t'(row_q)
                    + (top_q ? 0 : 1);
    assign pad_col  = mpad_pkg::addr_t'(tile_x_q) * `MPAD_TILE + (left_q ? 0 : 1);
    assign awaddr_o = dst_base_i + (pad_row * (mpad_pkg::addr_t'(mat_width_i) + 2) + pad_col)
                    * `MPAD_WORD_BYTES;
    assign awlen_o  = `MPAD_LEN_W'(n_cols - 3'd1);

    assign tile_ready_o = (state_q == mpad_pkg::WR_IDLE);
    assign awvalid_o    = (state_q == mpad_pkg::WR_ADDR);
    assign wvalid_o     = (state_q == mpad_pkg::WR_DATA);
    assign wlast_o      = wvalid_o && (col_q == n_cols - 3'd1);
    assign bready_o     = (state_q == mpad_pkg::WR_RESP);

    always_ff @(posedge clk) begin
        if (tile_valid_i && tile_ready_o) begin
            tile_q   <= tile_i;
            tile_x_q <= tile_x_i;
            tile_y_q <= tile_y_i;
            top_q    <= edge_top_i;
            bottom_q <= edge_bottom_i;
            left_q   <= edge_left_i;
            right_q  <= edge_right_i;
            last_q   <= tile_last_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= mpad_pkg::WR_IDLE;
            row_q     <= '0;
            col_q     <= '0;
            job_end_o <= 1'b0;
        end else begin
            job_end_o <= 1'b0;
            case (state_q)
                mpad_pkg::WR_IDLE: begin
                    if (tile_valid_i) begin
                        row_q   <= '0;
                        state_q <= mpad_pkg::WR_ADDR;
                    end
                end
                mpad_pkg::WR_ADDR: begin
                    if (awready_i) begin
                        col_q   <= '0;
                        state_q <= mpad_pkg::WR_DATA;
                    end
                end
                mpad_pkg::WR_DATA: begin
                    if (wready_i) begin
                        col_q <= col_q + 3'd1;
                        if (wlast_o) begin
                            state_q <= mpad_pkg::WR_RESP;
                        end
                    end
                end
                default: begin
                    if (bvalid_i) begin
                        row_q <= row_q + 3'd1;
                        if (last_row) begin
                            job_end_o <= last_q; // Final tile of the job
                            state_q   <= mpad_pkg::WR_IDLE;
                        end else begin
                            state_q <= mpad_pkg::WR_ADDR;
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- mpad_engine.sv
// Matrix padding DMA engine top level
// Chains sequencer, tile reader and tile writer, exposes the AXI master channels

`include "mpad_defines.svh"

module mpad_engine (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start_i,
    input  mpad_pkg::dim_t  width_i,
    input  mpad_pkg::addr_t src_addr_i,
    input  mpad_pkg::addr_t dst_addr_i,
    output logic            done_o,
    // AXI read
    output mpad_pkg::addr_t araddr_o,
    output logic [`MPAD_LEN_W-1:0] arlen_o,
    output logic            arvalid_o,
    input  logic            arready_i,
    input  mpad_pkg::word_t rdata_i,
    input  logic            rlast_i,
    input  logic            rvalid_i,
    output logic            rready_o,
    // AXI write
    output mpad_pkg::addr_t awaddr_o,
    output logic [`MPAD_LEN_W-1:0] awlen_o,
    output logic            awvalid_o,
    input  logic            awready_i,
    output mpad_pkg::word_t wdata_o,
    output logic            wlast_o,
    output logic            wvalid_o,
    input  logic            wready_i,
    input  logic            bvalid_i,
    output logic            bready_o
);
    // Job-wide command copies
    mpad_pkg::dim_t  mat_width;
    mpad_pkg::addr_t src_base;
    mpad_pkg::addr_t dst_base;

    // Sequencer to reader
    logic            desc_valid, desc_ready;
    mpad_pkg::dim_t  d_tile_x, d_tile_y;
    logic            d_top, d_bottom, d_left, d_right, d_last;

    // Reader to writer
    logic            tile_valid, tile_ready;
    mpad_pkg::tile_t tile;
    mpad_pkg::dim_t  t_tile_x, t_tile_y;
    logic            t_top, t_bottom, t_left, t_right, t_last;

    logic            job_end;

    mpad_tile_seq u_seq (
        .clk(clk), .rst_n(rst_n), .start_i(start_i), .width_i(width_i),
        .src_addr_i(src_addr_i), .dst_addr_i(dst_addr_i), .done_o(done_o),
        .desc_valid_o(desc_valid), .desc_ready_i(desc_ready),
        .tile_x_o(d_tile_x), .tile_y_o(d_tile_y),
        .edge_top_o(d_top), .edge_bottom_o(d_bottom),
        .edge_left_o(d_left), .edge_right_o(d_right), .tile_last_o(d_last),
        .mat_width_o(mat_width), .src_base_o(src_base), .dst_base_o(dst_base),
        .job_end_i(job_end)
    );

    mpad_tile_reader u_reader (
        .clk(clk), .rst_n(rst_n),
        .desc_valid_i(desc_valid), .desc_ready_o(desc_ready),
        .tile_x_i(d_tile_x), .tile_y_i(d_tile_y),
        .edge_top_i(d_top), .edge_bottom_i(d_bottom),
        .edge_left_i(d_left), .edge_right_i(d_right), .tile_last_i(d_last),
        .mat_width_i(mat_width), .src_base_i(src_base),
        .araddr_o(araddr_o), .arlen_o(arlen_o),
        .arvalid_o(arvalid_o), .arready_i(arready_i),
        .rdata_i(rdata_i), .rlast_i(rlast_i), .rvalid_i(rvalid_i), .rready_o(rready_o),
        .tile_valid_o(tile_valid), .tile_ready_i(tile_ready), .tile_o(tile),
        .tile_x_o(t_tile_x), .tile_y_o(t_tile_y),
        .edge_top_o(t_top), .edge_bottom_o(t_bottom),
        .edge_left_o(t_left), .edge_right_o(t_right), .tile_last_o(t_last)
    );

    mpad_tile_writer u_writer (
        .clk(clk), .rst_n(rst_n),
        .tile_valid_i(tile_valid), .tile_ready_o(tile_ready), .tile_i(tile),
        .tile_x_i(t_tile_x), .tile_y_i(t_tile_y),
        .edge_top_i(t_top), .edge_bottom_i(t_bottom),
        .edge_left_i(t_left), .edge_right_i(t_right), .tile_last_i(t_last),
        .mat_width_i(mat_width), .dst_base_i(dst_base),
        .awaddr_o(awaddr_o), .awlen_o(awlen_o),
        .awvalid_o(awvalid_o), .awready_i(awready_i),
        .wdata_o(wdata_o), .wlast_o(wlast_o), .wvalid_o(wvalid_o), .wready_i(wready_i),
        .bvalid_i(bvalid_i), .bready_o(bready_o), .job_end_o(job_end)
    );

endmodule

//--- tb_mpad_mem.sv
// AXI slave memory model for the padding engine testbench
// Random ready/valid stalls from an LCG, plus a poke port for preloading words

`include "mpad_defines.svh"

module tb_mpad_mem (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall_i,
    input  logic                   poke_i,
    input  logic [11:0]            poke_addr_i,
    input  mpad_pkg::word_t        poke_data_i,
    input  mpad_pkg::addr_t        araddr_i,
    input  logic [`MPAD_LEN_W-1:0] arlen_i,
    input  logic                   arvalid_i,
    output logic                   arready_o,
    output mpad_pkg::word_t        rdata_o,
    output logic                   rlast_o,
    output logic                   rvalid_o,
    input  logic                   rready_i,
    input  mpad_pkg::addr_t        awaddr_i,
    input  logic                   awvalid_i,
    output logic                   awready_o,
    input  mpad_pkg::word_t        wdata_i,
    input  logic                   wlast_i,
    input  logic                   wvalid_i,
    output logic                   wready_o,
    output logic                   bvalid_o,
    input  logic                   bready_i
);
    mpad_pkg::word_t        mem [4096]; // 16 KB, word indexed
    logic [31:0]            rnd;
    logic                   rd_busy;
    logic                   wr_busy;
    logic                   b_pend;    // Write burst done, response owed
    logic [11:0]            rd_ptr;
    logic [11:0]            wr_ptr;
    logic [`MPAD_LEN_W-1:0] rd_left;   // Beats left after the current one

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Handshakes complete on the rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
            b_pend  <= 1'b0;
        end else begin
            if (arvalid_i && arready_o) begin
                rd_busy <= 1'b1;
                rd_ptr  <= araddr_i[13:2];
                rd_left <= arlen_i;
            end
            if (rvalid_o && rready_i) begin
                rd_ptr  <= rd_ptr + 12'd1;
                rd_left <= rd_left - `MPAD_LEN_W'(1);
                rd_busy <= !rlast_o;
            end
            if (awvalid_i && awready_o) begin
                wr_busy <= 1'b1;
                wr_ptr  <= awaddr_i[13:2];
            end
            if (wvalid_i && wready_o) begin
                mem[wr_ptr] <= wdata_i;
                wr_ptr      <= wr_ptr + 12'd1;
                if (wlast_i) begin
                    wr_busy <= 1'b0;
                    b_pend  <= 1'b1;
                end
            end
            if (bvalid_o && bready_i) begin
                b_pend <= 1'b0;
            end
            if (poke_i) begin
                mem[poke_addr_i] <= poke_data_i;
            end
        end
    end

    // Outputs only change on the falling edge
    initial begin
        rnd       = 32'd76;
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        rdata_o   = '0;
        rlast_o   = 1'b0;
        awready_o = 1'b0;
        wready_o  = 1'b0;
        bvalid_o  = 1'b0;
        forever begin
            @(negedge clk);
            rnd       = lcg_next(rnd);
            arready_o = rst_n && !rd_busy && (!stall_i || rnd[16]);
            rvalid_o  = rst_n && rd_busy && (!stall_i || rnd[18]);
            rdata_o   = mem[rd_ptr];
            rlast_o   = (rd_left == '0);
            awready_o = rst_n && !wr_busy && !b_pend && (!stall_i || rnd[20]);
            wready_o  = rst_n && wr_busy && (!stall_i || rnd[22]);
            bvalid_o  = rst_n && b_pend && (!stall_i || rnd[24]); // Response may lag
        end
    end

endmodule

//--- tb_mpad_engine.sv
// Testbench for the matrix padding DMA engine
// Directed jobs check every padded word against the reflection rule

`include "mpad_defines.svh"

module tb_mpad_engine;
    // 34 tiles of about 60 cycles, x4 under stalls, plus one cycle per preloaded word
    localparam int FILL_WORDS  = 1320;
    localparam int TILE_CYCLES = 60 * 4;
    localparam int MAX_CYCLES  = 2 * (FILL_WORDS + 34 * TILE_CYCLES) + 1000;
    localparam logic [31:0] SENTINEL = 32'hDEADBEEF;

    logic                   clk = 1'b0;
    logic                   rst_n, start, stall_en, poke;
    logic [11:0]            poke_addr;
    mpad_pkg::word_t        poke_data, rdata, wdata;
    mpad_pkg::dim_t         width;
    mpad_pkg::addr_t        src_addr, dst_addr, araddr, awaddr;
    logic [`MPAD_LEN_W-1:0] arlen, awlen;
    logic                   done, arvalid, arready, rlast, rvalid, rready;
    logic                   awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    int                     cycles = 0;
    int                     w_beats;
    int                     w_len;

    mpad_engine mpad_engine_inst (
        .clk(clk), .rst_n(rst_n), .start_i(start), .width_i(width),
        .src_addr_i(src_addr), .dst_addr_i(dst_addr), .done_o(done),
        .araddr_o(araddr), .arlen_o(arlen), .arvalid_o(arvalid), .arready_i(arready),
        .rdata_i(rdata), .rlast_i(rlast), .rvalid_i(rvalid), .rready_o(rready),
        .awaddr_o(awaddr), .awlen_o(awlen), .awvalid_o(awvalid), .awready_i(awready),
        .wdata_o(wdata), .wlast_o(wlast), .wvalid_o(wvalid), .wready_i(wready),
        .bvalid_i(bvalid), .bready_o(bready)
    );

    tb_mpad_mem mem_model (
        .clk(clk), .rst_n(rst_n), .stall_i(stall_en),
        .poke_i(poke), .poke_addr_i(poke_addr), .poke_data_i(poke_data),
        .araddr_i(araddr), .arlen_i(arlen), .arvalid_i(arvalid), .arready_o(arready),
        .rdata_o(rdata), .rlast_o(rlast), .rvalid_o(rvalid), .rready_i(rready),
        .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
        .wdata_i(wdata), .wlast_i(wlast), .wvalid_i(wvalid), .wready_o(wready),
        .bvalid_o(bvalid), .bready_i(bready)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the engine never finished", cycles);
            $display("Test failures found");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // Burst shape on every handshake
    always @(posedge clk) begin
        if (arvalid && arready) check_value("arlen_o", 32'd3, 32'(arlen));
        if (awvalid && awready) begin
            w_len   = int'(awlen);
            w_beats = 0;
        end
        if (wvalid && wready) begin
            w_beats = w_beats + 1;
            check_value("wlast_o", 32'(w_beats == w_len + 1), 32'(wlast));
        end
    end

    // Padded index p in 0..w+1 to source index
    function automatic int src_index(input int p, input int w);
        if (p == 0) return 1;
        if (p == w + 1) return w - 2;
        return p - 1;
    endfunction

    function automatic logic [31:0] src_word(input int addr);
        return 32'(addr / 4 * 3 + 1);
    endfunction

    task automatic poke_word(input int addr, input logic [31:0] data);
        poke      = 1'b1;
        poke_addr = 12'(addr / 4);
        poke_data = data;
        @(negedge clk);
        poke = 1'b0;
    endtask

    task automatic run_job(input int w, input int src, input int dst, input logic stalls);
        int pw;
        int sr;
        int sc;
        pw = w + 2;
        for (int i = 0; i < w * w; i++) poke_word(src + 4 * i, src_word(src + 4 * i));
        for (int i = 0; i < pw * pw + 4; i++) poke_word(dst + 4 * i, SENTINEL); // 4 guard words
        check_value("done_o", 32'd1, 32'(done));
        stall_en = stalls;
        width    = mpad_pkg::dim_t'(w);
        src_addr = mpad_pkg::addr_t'(src);
        dst_addr = mpad_pkg::addr_t'(dst);
        start    = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_value("done_o", 32'd0, 32'(done));
        while (!done) @(negedge clk);
        for (int r = 0; r < pw; r++) begin
            for (int c = 0; c < pw; c++) begin
                sr = src_index(r, w);
                sc = src_index(c, w);
                check_value($sformatf("dst[%0d][%0d]", r, c), src_word(src + 4 * (sr * w + sc)),
                            mem_model.mem[12'(dst / 4 + r * pw + c)]);
            end
        end
        for (int i = 0; i < 4; i++) begin
            check_value($sformatf("guard[%0d]", i), SENTINEL,
                        mem_model.mem[12'(dst / 4 + pw * pw + i)]);
        end
    endtask

    task automatic reset_and_zero_width();
        check_value("done_o", 32'd1, 32'(done));
        check_value("arvalid_o", 32'd0, 32'(arvalid));
        check_value("awvalid_o", 32'd0, 32'(awvalid));
        check_value("wvalid_o", 32'd0, 32'(wvalid));
        check_value("rready_o", 32'd0, 32'(rready));
        check_value("bready_o", 32'd0, 32'(bready));
        width = '0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (50) begin
            @(negedge clk);
            check_value("done_o", 32'd1, 32'(done));
            check_value("arvalid_o", 32'd0, 32'(arvalid));
        end
    endtask

    task automatic single_tile_job();
        run_job(4, 'h0000, 'h0400, 1'b0); // One tile on all four edges
    endtask

    task automatic corner_tile_job();
        run_job(8, 'h0800, 'h0C00, 1'b0);
    endtask

    task automatic stalled_full_job();
        run_job(16, 'h1000, 'h1400, 1'b1);
    endtask

    task automatic back_to_back_jobs();
        run_job(12, 'h2000, 'h3000, 1'b1);
        run_job(8, 'h2800, 'h3800, 1'b1);
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        stall_en  = 1'b0;
        poke      = 1'b0;
        poke_addr = '0;
        poke_data = '0;
        width     = '0;
        src_addr  = '0;
        dst_addr  = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        reset_and_zero_width();
        single_tile_job();
        corner_tile_job();
        stalled_full_job();
        back_to_back_jobs();
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
mpad_pkg.sv
mpad_tile_seq.sv
mpad_tile_reader.sv
mpad_tile_writer.sv
mpad_engine.sv
tb_mpad_mem.sv
tb_mpad_engine.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only when the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_mpad_engine -f tb.f -o tb_mpad_sim &&
./obj_dir/tb_mpad_sim | tee /dev/stderr | grep -F 'All tests passed!' > /dev/null &&
echo "Simulation PASSED" || { echo "Simulation FAILED"; exit 1; }
